/* Bender.yml */
package:
  name: cpu16

sources:
  - hdl/cpu_pkg.sv
  - hdl/control_unit.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/result_unit.sv
  - hdl/pc_unit.sv
  - hdl/cpu_top.sv
  - target: test
    files:
      - tests/tb_cpu.sv

/* filelist.f */
hdl/cpu_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/result_unit.sv
hdl/pc_unit.sv
hdl/cpu_top.sv
tests/tb_cpu.sv

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu (
  input  cpu_pkg::word_t rs_data,
  input  cpu_pkg::word_t rt_data,
  input  cpu_pkg::imm_t  imm,
  input  cpu_pkg::ctrl_t ctrl,
  output cpu_pkg::word_t alu_result,
  output logic           zero
);
  import cpu_pkg::*;

  word_t imm_ext;
  word_t op_a;
  word_t op_b;

  assign imm_ext = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm}; // sign extend
  assign op_a    = rs_data;
  assign op_b    = ctrl.alu_src ? imm_ext : rt_data;

  always_comb begin
    case (ctrl.alu_op)
      alu_add:  alu_result = op_a + op_b;
      alu_sub:  alu_result = op_a - op_b;
      alu_not:  alu_result = ~op_a;
      alu_and:  alu_result = op_a & op_b;
      alu_or:   alu_result = op_a | op_b;
      alu_nand: alu_result = ~(op_a & op_b);
      alu_nor:  alu_result = ~(op_a | op_b);
      alu_mov:  alu_result = op_a;
      alu_li:   alu_result = op_b;
      default:  alu_result = '0;
    endcase
  end

  // used by beq/bne
  assign zero = (alu_result == '0);

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
  input  logic [15:0]            instr,
  output cpu_pkg::ctrl_t         ctrl,
  output cpu_pkg::instr_fields_t fields
);
  import cpu_pkg::*;

  opcode_e opcode;

  assign opcode = opcode_e'(instr[15:12]);

  // field split, overlapping fields are decoded per opcode downstream
  assign fields.opcode = opcode;
  assign fields.rs     = instr[11:9];
  assign fields.rt     = instr[8:6];
  assign fields.rd     = instr[5:3];
  assign fields.imm    = instr[5:0];
  assign fields.target = instr[7:0];

  always_comb begin
    ctrl        = '0;      // nothing written, nothing taken
    ctrl.mem_op = mem_nop;
    ctrl.alu_op = alu_add;
    case (opcode)
      op_add, op_sub, op_not, op_and, op_or, op_nand, op_nor, op_mov: begin
        ctrl.reg_dst   = 1'b1; // r-type result goes to rd
        ctrl.reg_write = 1'b1;
        case (opcode)
          op_sub:  ctrl.alu_op = alu_sub;
          op_not:  ctrl.alu_op = alu_not;
          op_and:  ctrl.alu_op = alu_and;
          op_or:   ctrl.alu_op = alu_or;
          op_nand: ctrl.alu_op = alu_nand;
          op_nor:  ctrl.alu_op = alu_nor;
          op_mov:  ctrl.alu_op = alu_mov;
          default: ctrl.alu_op = alu_add;
        endcase
      end
      op_addi, op_subi: begin
        ctrl.alu_src   = 1'b1; // rs +/- imm into rt
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = (opcode == op_subi) ? alu_sub : alu_add;
      end
      op_li: begin
        ctrl.alu_src   = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_li;
      end
      op_lw: begin
        ctrl.alu_src    = 1'b1; // address = rs + imm
        ctrl.mem_to_reg = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_op     = mem_read;
      end
      op_sw: begin
        ctrl.alu_src = 1'b1;
        ctrl.mem_op  = mem_write;
      end
      op_beq: begin
        ctrl.alu_op = alu_sub; // compare via zero flag
        ctrl.beq    = 1'b1;
      end
      op_bne: begin
        ctrl.alu_op = alu_sub;
        ctrl.bne    = 1'b1;
      end
      op_jump: begin
        ctrl.address_src = 1'b1;
      end
      default: begin
        ctrl = '0;
      end
    endcase
  end

endmodule

/* hdl/cpu_pkg.sv */
package cpu_pkg;

  localparam int WORD_W   = 16;
  localparam int PC_W     = 8;
  localparam int REG_W    = 3;
  localparam int IMM_W    = 6;
  localparam int NUM_REGS = 8;

  typedef logic [WORD_W-1:0] word_t;     // data word
  typedef logic [PC_W-1:0]   pc_t;       // instruction address
  typedef logic [REG_W-1:0]  reg_addr_t; // register number
  typedef logic [IMM_W-1:0]  imm_t;      // raw immediate field

  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_addi = 4'd1,
    op_sub  = 4'd2,
    op_subi = 4'd3,
    op_not  = 4'd4,
    op_and  = 4'd5,
    op_or   = 4'd6,
    op_nand = 4'd7,
    op_nor  = 4'd8,
    op_mov  = 4'd9,
    op_li   = 4'd10,
    op_lw   = 4'd11,
    op_sw   = 4'd12,
    op_beq  = 4'd13,
    op_bne  = 4'd14,
    op_jump = 4'd15
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_not  = 4'd2,
    alu_and  = 4'd3,
    alu_or   = 4'd4,
    alu_nand = 4'd5,
    alu_nor  = 4'd6,
    alu_mov  = 4'd7, // pass operand a
    alu_li   = 4'd8  // pass operand b
  } alu_op_e;

  typedef enum logic [1:0] {
    mem_nop   = 2'd0,
    mem_read  = 2'd1,
    mem_write = 2'd2
  } mem_op_e;

  typedef struct packed {
    logic    reg_dst;     // 1 = rd, 0 = rt
    logic    alu_src;     // 1 = immediate as operand b
    logic    mem_to_reg;
    logic    reg_write;
    mem_op_e mem_op;
    alu_op_e alu_op;
    logic    beq;
    logic    bne;
    logic    address_src; // jump target to pc
  } ctrl_t;

  typedef struct packed {
    opcode_e   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    pc_t       target;
  } instr_fields_t;

endpackage

/* hdl/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [15:0]        instr,
  output cpu_pkg::pc_t       instr_addr,
  output logic               wb_en,
  output cpu_pkg::reg_addr_t wb_reg,
  output cpu_pkg::word_t     wb_data
);
  import cpu_pkg::*;

  ctrl_t         ctrl;
  instr_fields_t fields;
  word_t         rs_data;
  word_t         rt_data;
  word_t         alu_result;
  logic          zero;

  control_unit u_control_unit (
    .instr  (instr),
    .ctrl   (ctrl),
    .fields (fields)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs      (fields.rs),
    .rt      (fields.rt),
    .ctrl    (ctrl),
    .rd      (fields.rd),
    .wb_data (wb_data),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .wb_reg  (wb_reg)
  );

  alu u_alu (
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .imm        (fields.imm),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .zero       (zero)
  );

  result_unit #(
    .DMEM_DEPTH (DMEM_DEPTH)
  ) u_result_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .store_data (rt_data), // sw stores rt
    .wb_data    (wb_data)
  );

  pc_unit u_pc_unit (
    .clk    (clk),
    .rst_n  (rst_n),
    .ctrl   (ctrl),
    .zero   (zero),
    .imm    (fields.imm),
    .target (fields.target),
    .pc     (instr_addr)
  );

  assign wb_en = ctrl.reg_write; // retire strobe

endmodule

/* hdl/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  logic           zero,
  input  cpu_pkg::imm_t  imm,
  input  cpu_pkg::pc_t   target,
  output cpu_pkg::pc_t   pc
);
  import cpu_pkg::*;

  pc_t  pc_plus1;
  pc_t  offset;
  pc_t  pc_next;
  logic taken;

  assign pc_plus1 = pc + 8'd1;
  assign offset   = {{(PC_W-IMM_W){imm[IMM_W-1]}}, imm};

  // beq on equal, bne on not equal
  assign taken = (ctrl.beq && zero) || (ctrl.bne && !zero);

  always_comb begin
    if (ctrl.address_src) begin
      pc_next = target;
    end else if (taken) begin
      pc_next = pc_plus1 + offset; // wraps at 8 bits
    end else begin
      pc_next = pc_plus1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= '0;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic               clk,
  input  logic               rst_n,
  input  cpu_pkg::reg_addr_t rs,
  input  cpu_pkg::reg_addr_t rt,
  input  cpu_pkg::ctrl_t     ctrl,
  input  cpu_pkg::reg_addr_t rd,
  input  cpu_pkg::word_t     wb_data,
  output cpu_pkg::word_t     rs_data,
  output cpu_pkg::word_t     rt_data,
  output cpu_pkg::reg_addr_t wb_reg
);
  import cpu_pkg::*;

  word_t regs [NUM_REGS];

  // combinational read ports
  assign rs_data = regs[rs];
  assign rt_data = regs[rt];

  assign wb_reg = ctrl.reg_dst ? rd : rt; // i-type writes rt

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write) begin
      regs[wb_reg] <= wb_data;
    end
  end

endmodule

/* hdl/result_unit.sv */
`timescale 1ns/100ps

module result_unit #(
  parameter int DMEM_DEPTH = 64
) (
  input  logic           clk,
  input  logic           rst_n,
  input  cpu_pkg::ctrl_t ctrl,
  input  cpu_pkg::word_t alu_result,
  input  cpu_pkg::word_t store_data,
  output cpu_pkg::word_t wb_data
);
  import cpu_pkg::*;

  localparam int ADDR_W = $clog2(DMEM_DEPTH);

  word_t             dmem [DMEM_DEPTH];
  logic [ADDR_W-1:0] dmem_addr;
  word_t             load_data;

  // address wraps on the memory depth
  assign dmem_addr = ADDR_W'(alu_result % DMEM_DEPTH);

  assign load_data = dmem[dmem_addr]; // lw

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (ctrl.mem_op == mem_write) begin
      dmem[dmem_addr] <= store_data; // sw
    end
  end

  // write-back mux
  assign wb_data = ctrl.mem_to_reg ? load_data : alu_result;

endmodule

/* tests/cpu_vectors.txt */
// columns: expected pc _ instruction _ wb_en _ wb_reg _ wb_data (hex)
// wb_reg and wb_data are zero where no register is written
00_a045_1_1_0005 // li r1, 5
01_a0bd_1_2_fffd // li r2, -3
02_0298_1_3_0002 // add r3 = r1 + r2
03_1307_1_4_000c // addi r4 = r1 + 7
04_22a8_1_5_0008 // sub r5 = r1 - r2
05_3981_1_6_000b // subi r6 = r4 - 1
06_4238_1_7_fffa // not r7 = ~r1
07_5998_1_3_0008 // and r3 = r4 & r6
08_6328_1_5_000d // or r5 = r1 | r4
09_7330_1_6_fffb // nand r6 = ~(r1 & r4)
0a_8310_1_2_fff2 // nor r2 = ~(r1 | r4)
0b_9638_1_7_0008 // mov r7 = r3
0c_c342_0_0_0000 // sw r5 -> [r1 + 2]
0d_b382_1_6_000d // lw r6 <- [r1 + 2]
0e_b9c1_1_7_0000 // lw r7 <- [r4 + 1], never written
0f_b8bb_1_2_000d // lw r2 <- [r4 - 5]
10_db82_0_0_0000 // beq r5, r6 taken, +2
13_eb85_0_0_0000 // bne r5, r6 not taken
14_d303_0_0_0000 // beq r1, r4 not taken
15_e303_0_0_0000 // bne r1, r4 taken, +3
19_f040_0_0_0000 // jump 0x40
40_1241_1_1_0006 // addi r1 = r1 + 1
41_e2fe_0_0_0000 // bne r1, r3 taken, -2
40_1241_1_1_0007
41_e2fe_0_0_0000
40_1241_1_1_0008
41_e2fe_0_0_0000 // r1 == r3, falls through
42_d2fc_0_0_0000 // beq r1, r3 taken, -4
3f_f0f0_0_0_0000 // jump 0xf0
f0_02e0_1_4_0010 // add r4 = r1 + r3
f1_c11f_0_0_0000 // sw r4 -> [r0 + 31]
f2_b357_1_5_0010 // lw r5 <- [r1 + 23]
f3_d00f_0_0_0000 // beq r0, r0 taken, pc wraps to 0x03
03_1307_1_4_000f // addi r4 = r1 + 7
04_22a8_1_5_fffb // sub r5 = r1 - r2

/* tests/tb_cpu.sv */
`timescale 1ns/100ps

module tb_cpu;
  import cpu_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_VEC      = 35;
  localparam int MAX_CYCLES   = NUM_VEC + RESET_CYCLES + 20;
  localparam int SAMPLE_DELAY = CLK_PERIOD / 2 - 10; // just before the rising edge

  // one line of the vector file
  typedef struct packed {
    logic [7:0]  pc;
    logic [15:0] instr;
    logic [3:0]  wb_en;
    logic [3:0]  wb_reg;
    logic [15:0] wb_data;
  } vector_t;

  logic        clk;
  logic        rst_n;
  logic [15:0] instr;
  pc_t         instr_addr;
  logic        wb_en;
  reg_addr_t   wb_reg;
  word_t       wb_data;

  logic [47:0] vector_mem [NUM_VEC];
  vector_t     vec;
  int          cycle_count;

  cpu_top #(
    .DMEM_DEPTH (64)
  ) UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .instr      (instr),
    .instr_addr (instr_addr),
    .wb_en      (wb_en),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  // run limit
  initial begin
    cycle_count = 0;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the vector replay did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1);
    end
  end

  task automatic compare_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_vector_file();
    assert (!$isunknown(vector_mem[0]) && !$isunknown(vector_mem[NUM_VEC-1])) else begin
      $display("the vector file tests/cpu_vectors.txt could not be read completely");
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic check_writeback(input vector_t v);
    compare_value("wb_en", {15'd0, v.wb_en[0]}, {15'd0, wb_en});
    if (v.wb_en[0]) begin // reg and data only matter on a retired write
      compare_value("wb_reg", {13'd0, v.wb_reg[2:0]}, {13'd0, wb_reg});
      compare_value("wb_data", v.wb_data, wb_data);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    instr = 16'h0000;
    $readmemh("tests/cpu_vectors.txt", vector_mem);
    check_vector_file();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_VEC; i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      vec = vector_mem[i];
      compare_value("instr_addr", {8'd0, vec.pc}, {8'd0, instr_addr});
      instr = vec.instr; // testbench acts as instruction memory
      #(SAMPLE_DELAY);
      check_writeback(vec);
    end

    @(negedge clk);
    instr = 16'h0000;
    $display("No errors");
    $finish;
  end

endmodule
